/* design/keypad_pkg.sv */
/*
 * Keypad matrix size, scan and debounce timing, and the shared key types.
 * SCAN_DWELL and DEBOUNCE_CYCLES are sized for simulation, so a real board
 * rescales them to its clock (e.g. about 20 ms of hold time).
 */
package keypad_pkg;

    // ==============================
    // Matrix and timing constants
    // ==============================
    localparam int KEY_ROWS        = 4;
    localparam int KEY_COLS        = 4;
    localparam int SCAN_DWELL      = 8;   // Cycles per driven column
    localparam int SYNC_STAGES     = 2;   // Row synchronizer depth
    localparam int DEBOUNCE_CYCLES = 64;  // Hold time before a key is accepted
    localparam int FIFO_DEPTH      = 8;   // Key events held

    // Derived widths
    localparam int COL_W      = $clog2(KEY_COLS);
    localparam int ROW_W      = $clog2(KEY_ROWS);
    localparam int DWELL_W    = $clog2(SCAN_DWELL);
    localparam int DEB_CNT_W  = $clog2(DEBOUNCE_CYCLES + 2);  // Counts one past the hold
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;               // Must hold FIFO_DEPTH itself

    // ==============================
    // Types
    // ==============================
    typedef logic [3:0] key_code_t;  // row * 4 + col

    // Scanner to encoder, sampled on the last dwell cycle of a column
    typedef struct packed {
        logic                hit;         // Some row low in the active column
        logic [KEY_ROWS-1:0] row_onehot;  // Active high, one bit per row pulled low
        logic [COL_W-1:0]    col_idx;     // Column driven low
    } scan_hit_t;

    // FIFO payload
    typedef struct packed {
        key_code_t code;
        logic      ghost_seen;  // A ghost pattern was seen before this press
    } key_event_t;

endpackage

/* design/wb_pkg.sv */
/*
 * Wishbone classic bus structs and the keypad register map.
 * Word addresses only, no byte selects, no ERR or RTY.
 */
package wb_pkg;

    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;

    // Master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;  // Word address
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // ==============================
    // Register map
    // ==============================
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 4'd0;  // count, overflow, key_valid
    localparam logic [WB_ADR_W-1:0] REG_DATA   = 4'd1;  // FIFO head, read pops
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 4'd2;  // scan_en, irq_en, ovf clear

    // CTRL bit positions
    localparam int CTRL_SCAN_EN  = 0;
    localparam int CTRL_IRQ_EN   = 1;
    localparam int CTRL_OVF_CLR  = 2;  // Write-one-to-clear, reads as 0

endpackage

/* design/keypad_scanner.sv */
/*
 * Drives one column low at a time, SCAN_DWELL cycles each, and samples
 * the pulled-up rows through a SYNC_STAGES synchronizer.
 * A hit is only reported on the last dwell cycle; scan_stop holds there.
 */
module keypad_scanner import keypad_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,     // CTRL scan_en
    input  logic                scan_stop,  // From debouncer, freezes the column
    input  logic [KEY_ROWS-1:0] rows,       // Active low, pulled up
    output logic [KEY_COLS-1:0] cols,       // Active low, one at a time
    output scan_hit_t           hit
);

    logic [DWELL_W-1:0]  dwell_cnt;
    logic [COL_W-1:0]    col_idx;
    logic [COL_W-1:0]    col_next;
    logic                last_dwell;
    logic                advance;
    logic [KEY_ROWS-1:0] row_sync [SYNC_STAGES];

    // ==============================
    // Column rotation
    // ==============================
    assign last_dwell = (dwell_cnt == DWELL_W'(SCAN_DWELL - 1));
    assign advance    = last_dwell && !scan_stop;  // Frozen while a key is being debounced

    always_comb begin
        col_next = col_idx;
        if (advance) begin
            col_next = (col_idx == COL_W'(KEY_COLS - 1)) ? '0 : col_idx + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            col_idx   <= '0;
            cols      <= '1;  // All released
        end else if (!enable) begin
            dwell_cnt <= '0;
            cols      <= '1;  // Scan off, nothing driven
        end else begin
            if (advance) begin
                dwell_cnt <= '0;
            end else if (!last_dwell) begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
            col_idx <= col_next;
            cols    <= ~(KEY_COLS'(1) << col_next);  // Registered so no glitch on the pins
        end
    end

    // ==============================
    // Row synchronizer
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                row_sync[i] <= '1;  // Idle rows read high
            end
        end else begin
            row_sync[0] <= rows;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                row_sync[i] <= row_sync[i-1];
            end
        end
    end

    // Rows have settled by the last dwell cycle of the column
    assign hit.row_onehot = ~row_sync[SYNC_STAGES-1];
    assign hit.col_idx    = col_idx;
    assign hit.hit        = enable && last_dwell && (|hit.row_onehot);

endmodule

/* design/key_encoder.sv */
/*
 * Combinational row/column to key code.
 * Only one key per column is accepted; two or more low rows flag a ghost
 * and hold key_detected low. Keys in different columns are seen one by one.
 */
module key_encoder import keypad_pkg::*; (
    input  scan_hit_t hit,
    output logic      key_detected,  // Exactly one row low in the active column
    output key_code_t key_code,
    output logic      ghost          // Two or more rows low
);

    logic [ROW_W-1:0] row_idx;
    logic [2:0]       row_count;  // Up to KEY_ROWS rows set

    // ==============================
    // Row count and index
    // ==============================
    always_comb begin
        row_count = '0;
        row_idx   = '0;
        for (int r = 0; r < KEY_ROWS; r++) begin
            if (hit.row_onehot[r]) begin
                row_count = row_count + 1'b1;
                row_idx   = ROW_W'(r);  // Only meaningful when a single row is set
            end
        end
    end

    // ==============================
    // Outputs
    // ==============================
    always_comb begin
        key_detected = hit.hit && (row_count == 3'd1);
        ghost        = hit.hit && (row_count > 3'd1);
        // code = row * KEY_COLS + col
        if (key_detected) begin
            key_code = key_code_t'({row_idx, hit.col_idx});
        end else begin
            key_code = '0;
        end
    end

endmodule

/* design/keypad_debouncer.sv */
/*
 * Two-state hold-time debouncer. A key must stay detected, with the same
 * code, for DEBOUNCE_CYCLES; press then pulses once per key-down.
 * scan_stop is high from the first detection so the scanner stays put.
 */
module keypad_debouncer import keypad_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_detected,
    input  key_code_t  key_code,
    input  logic       ghost,
    output logic       key_valid,      // Level, while the accepted key is held
    output key_code_t  debounced_key,  // Zero unless key_valid
    output logic       scan_stop,
    output logic       press,          // One cycle at acceptance
    output key_event_t press_event
);

    typedef enum logic {
        IDLE,
        DEBOUNCING
    } deb_state_t;

    deb_state_t           state;
    logic [DEB_CNT_W-1:0] hold_cnt;     // Saturates at DEBOUNCE_CYCLES + 1
    key_code_t            latched_key;
    logic                 ghost_flag;   // Ghost seen since the last press

    // ==============================
    // Debounce FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            hold_cnt    <= '0;
            latched_key <= '0;
            ghost_flag  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ghost) ghost_flag <= 1'b1;
                    if (key_detected) begin
                        state       <= DEBOUNCING;
                        latched_key <= key_code;
                        hold_cnt    <= '0;
                    end
                end
                DEBOUNCING: begin
                    if (!key_detected || key_code != latched_key) begin
                        state <= IDLE;  // Released or moved, start over
                    end else if (hold_cnt <= DEB_CNT_W'(DEBOUNCE_CYCLES)) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                    if (press) ghost_flag <= 1'b0;  // Flag handed to this event
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ==============================
    // Outputs
    // ==============================
    // key_detected is included so the hit cycle itself already freezes the scan
    assign scan_stop = (state == DEBOUNCING) || key_detected;

    assign press     = (state == DEBOUNCING) && key_detected
                       && (key_code == latched_key)
                       && (hold_cnt == DEB_CNT_W'(DEBOUNCE_CYCLES));
    assign key_valid = (state == DEBOUNCING) && (hold_cnt >= DEB_CNT_W'(DEBOUNCE_CYCLES));

    assign debounced_key          = key_valid ? latched_key : '0;
    assign press_event.code       = latched_key;
    assign press_event.ghost_seen = ghost_flag;

endmodule

/* design/key_fifo.sv */
/*
 * Synchronous FIFO of FIFO_DEPTH entries, payload type T.
 * Push while full is dropped and pop while empty is ignored;
 * dout shows the head without popping. Storage is not reset.
 */
module key_fifo import keypad_pkg::*; #(
    parameter type T = key_event_t
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  T                      din,
    input  logic                  pop,
    output T                      dout,
    output logic [FIFO_CNT_W-1:0] count,
    output logic                  full,
    output logic                  empty
);

    T                      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ==============================
    // Storage
    // ==============================
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    assign dout = mem[rd_ptr];  // Head, valid when !empty

    // ==============================
    // Pointers and occupancy
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

/* design/keypad_wb_ctrl.sv */
/*
 * Wishbone classic slave for the keypad. ack is registered, one cycle,
 * and no new request is taken while it is high. Byte selects are ignored.
 * A DATA read pops the FIFO on its ack cycle when the FIFO is nonempty.
 */
module keypad_wb_ctrl import keypad_pkg::*, wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    input  key_event_t            fifo_head,
    input  logic [FIFO_CNT_W-1:0] fifo_count,
    input  logic                  fifo_full,
    input  logic                  push_seen,   // Debouncer press, same cycle as FIFO push
    input  logic                  key_valid,
    output logic                  fifo_pop,
    output logic                  scan_en,
    output logic                  irq
);

    logic                req_valid;
    logic                ack_q;
    logic [WB_DAT_W-1:0] rd_data_q;
    logic [WB_DAT_W-1:0] rd_data;
    logic                irq_en;
    logic                overflow;   // Sticky, push lost to a full FIFO
    logic                nonempty;

    assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;
    assign nonempty  = (fifo_count != '0);

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            REG_STATUS: begin
                rd_data[FIFO_CNT_W-1:0] = fifo_count;
                rd_data[4]              = overflow;
                rd_data[5]              = key_valid;
            end
            REG_DATA: begin
                rd_data[3:0] = fifo_head.code;
                rd_data[4]   = fifo_head.ghost_seen;
                rd_data[8]   = nonempty;  // Code bits are stale when clear
            end
            REG_CTRL: begin
                rd_data[CTRL_SCAN_EN] = scan_en;
                rd_data[CTRL_IRQ_EN]  = irq_en;
            end
            default: rd_data = '0;
        endcase
    end

    // ==============================
    // Bus handshake and FIFO pop
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            fifo_pop <= 1'b0;
        end else begin
            ack_q    <= req_valid;
            // Lines up with the ack cycle, head was captured in rd_data_q
            fifo_pop <= req_valid && !wb_req.we && (wb_req.adr == REG_DATA) && nonempty;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && !wb_req.we) rd_data_q <= rd_data;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data_q;

    // ==============================
    // Control and status registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_en  <= 1'b1;  // Scanning from reset
            irq_en   <= 1'b0;
            overflow <= 1'b0;
            irq      <= 1'b0;
        end else begin
            if (req_valid && wb_req.we && wb_req.adr == REG_CTRL) begin
                scan_en <= wb_req.dat[CTRL_SCAN_EN];
                irq_en  <= wb_req.dat[CTRL_IRQ_EN];
                if (wb_req.dat[CTRL_OVF_CLR]) overflow <= 1'b0;
            end
            if (push_seen && fifo_full) overflow <= 1'b1;  // Set wins over clear
            irq <= irq_en && nonempty;  // Level, drops when drained
        end
    end

endmodule

/* design/keypad_top.sv */
/*
 * 4x4 keypad controller with a Wishbone classic slave port.
 * Key-down to FIFO entry takes at most
 * 4*SCAN_DWELL + SYNC_STAGES + DEBOUNCE_CYCLES + 3 cycles.
 */
module keypad_top import keypad_pkg::*, wb_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  wb_req_t             wb_req,
    output wb_rsp_t             wb_rsp,
    input  logic [KEY_ROWS-1:0] rows,
    output logic [KEY_COLS-1:0] cols,
    output logic                irq
);

    // ==============================
    // Internal wires
    // ==============================
    scan_hit_t             scan_hit;
    logic                  key_detected;
    key_code_t             key_code;
    logic                  ghost;
    logic                  scan_stop;
    logic                  key_valid;
    logic                  press;
    key_event_t            press_event;
    key_event_t            fifo_head;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  fifo_full;
    logic                  fifo_pop;
    logic                  scan_en;

    keypad_scanner u_scanner (
        .clk(clk), .rst_n(rst_n),
        .enable(scan_en), .scan_stop(scan_stop),
        .rows(rows), .cols(cols), .hit(scan_hit)
    );

    key_encoder u_encoder (
        .hit(scan_hit), .key_detected(key_detected),
        .key_code(key_code), .ghost(ghost)
    );

    // debounced_key has no register field, only key_valid goes to STATUS
    keypad_debouncer u_debouncer (
        .clk(clk), .rst_n(rst_n),
        .key_detected(key_detected), .key_code(key_code), .ghost(ghost),
        .key_valid(key_valid), .debounced_key(), .scan_stop(scan_stop),
        .press(press), .press_event(press_event)
    );

    key_fifo #(.T(key_event_t)) u_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(press), .din(press_event), .pop(fifo_pop), .dout(fifo_head),
        .count(fifo_count), .full(fifo_full), .empty()  // Controller uses count
    );

    keypad_wb_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .fifo_head(fifo_head), .fifo_count(fifo_count), .fifo_full(fifo_full),
        .push_seen(press), .key_valid(key_valid),
        .fifo_pop(fifo_pop), .scan_en(scan_en), .irq(irq)
    );

endmodule

/* bench/keypad_tb.sv */
/*
 * Testbench for keypad_top. A 4x4 matrix model answers the driven columns.
 * A table of key sets, hold times and outcomes runs through Wishbone reads.
 * Hold times scale with the package timing, so a rescaled build stays valid.
 */
module keypad_tb import keypad_pkg::*, wb_pkg::*; ();

    // ==============================
    // Timing and table layout
    // ==============================
    localparam int LATENCY    = 4 * SCAN_DWELL + SYNC_STAGES + DEBOUNCE_CYCLES + 3;
    localparam int HOLD_NORM  = LATENCY + 4 * SCAN_DWELL;  // Bound plus a full scan
    localparam int HOLD_SHORT = DEBOUNCE_CYCLES - SCAN_DWELL;  // Seen by the scan, let go early
    localparam int HOLD_LONG  = 3 * LATENCY;
    localparam int BUS_LIMIT  = 20;   // Cycles to wait for ack
    localparam int POLL_LIMIT = 40;   // STATUS reads before giving up
    localparam int N_STIM     = 16;

    localparam logic [1:0] OUT_ENTRY = 2'd0;
    localparam logic [1:0] OUT_NONE  = 2'd1;
    localparam logic [1:0] OUT_GHOST = 2'd2;

    typedef struct packed {
        logic [15:0] keys;     // Bit row * 4 + col is held down
        logic [15:0] hold;     // Cycles held
        logic [1:0]  outcome;
        key_code_t   code;     // Expected code for an entry
        logic        drain;    // Empty the FIFO afterwards
    } stim_t;

    logic                clk;
    logic                rst_n;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    logic [KEY_ROWS-1:0] rows;
    logic [KEY_COLS-1:0] cols;
    logic                irq;

    logic [15:0] pressed_keys;
    stim_t       stim [N_STIM];
    logic [4:0]  exp_q [$];       // {ghost, code} in FIFO order
    logic        exp_ovf;
    logic        ghost_pending;   // Ghost seen since the last accepted press
    int          errors;
    int          timeouts;

    keypad_top UUT (
        .clk(clk), .rst_n(rst_n),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .rows(rows), .cols(cols), .irq(irq)
    );

    always #20 clk = ~clk;

    // ==============================
    // Keypad matrix model
    // ==============================
    function automatic logic [KEY_ROWS-1:0] matrix_rows(input logic [15:0] keys,
                                                       input logic [KEY_COLS-1:0] col_drv);
        logic [KEY_ROWS-1:0] r_out;
        r_out = '1;  // Pull-ups
        for (int r = 0; r < KEY_ROWS; r++) begin
            for (int c = 0; c < KEY_COLS; c++) begin
                if (keys[r * KEY_COLS + c] && !col_drv[c]) r_out[r] = 1'b0;
            end
        end
        return r_out;
    endfunction

    // Rows follow cols half a cycle later, on the falling edge
    always @(negedge clk) begin
        rows <= matrix_rows(pressed_keys, cols);
    end

    function automatic logic [15:0] one_key(input key_code_t code);
        return 16'(1) << code;
    endfunction

    function automatic stim_t make_stim(input logic [15:0] keys, input key_code_t code,
                                        input int hold, input logic [1:0] outcome,
                                        input logic drain);
        stim_t s;
        s.keys    = keys;
        s.code    = code;
        s.hold    = 16'(hold);
        s.outcome = outcome;
        s.drain   = drain;
        return s;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    // ==============================
    // Wishbone master
    // ==============================
    task automatic bus_cycle(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited     = 0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < BUS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            timeouts++;
            $display("Timeout: no ack from the Wishbone slave at address %0d", adr);
        end
        wb_req.cyc = 1'b0;  // Drop the strobe right after ack
        wb_req.stb = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    // ==============================
    // Checking helpers
    // ==============================
    task automatic poll_count(input int exp_count, output logic [31:0] status);
        int tries;
        tries = 0;
        wb_read(REG_STATUS, status);
        while (status[3:0] != exp_count[3:0] && tries < POLL_LIMIT) begin
            repeat (SCAN_DWELL) @(negedge clk);
            wb_read(REG_STATUS, status);
            tries++;
        end
        if (status[3:0] != exp_count[3:0]) begin
            timeouts++;
            $display("Timeout: STATUS count stuck at %0d while waiting for %0d",
                     status[3:0], exp_count);
        end
    endtask

    // Reads every expected event in order, then one read on the empty FIFO
    task automatic drain_fifo();
        logic [31:0] dat;
        logic [4:0]  exp_ev;
        while (exp_q.size() > 0) begin
            exp_ev = exp_q.pop_front();
            wb_read(REG_DATA, dat);
            if (dat[8] !== 1'b1 || dat[4:0] !== exp_ev) begin
                flag_error($sformatf("DATA 0x%03h, expected code %0d ghost %0b", dat[8:0],
                                     exp_ev[3:0], exp_ev[4]));
            end
        end
        wb_read(REG_DATA, dat);
        if (dat[8] !== 1'b0) flag_error("DATA nonempty bit set on an empty FIFO");
        wb_read(REG_STATUS, dat);
        if (dat[3:0] !== 4'd0) flag_error($sformatf("count %0d after drain", dat[3:0]));
    endtask

    task automatic run_entry(input int i);
        stim_t       s;
        logic [31:0] status;
        logic        exp_valid;
        s         = stim[i];
        exp_valid = (s.outcome == OUT_ENTRY);
        pressed_keys <= s.keys;
        repeat (s.hold) @(negedge clk);
        wb_read(REG_STATUS, status);  // Key still down here
        if (status[5] !== exp_valid) begin
            flag_error($sformatf("entry %0d key_valid %0b, expected %0b", i, status[5],
                                 exp_valid));
        end
        pressed_keys <= '0;
        case (s.outcome)
            OUT_ENTRY: begin
                if (exp_q.size() < FIFO_DEPTH) exp_q.push_back({ghost_pending, s.code});
                else exp_ovf = 1'b1;  // Lost to a full FIFO
                ghost_pending = 1'b0;
            end
            OUT_GHOST: ghost_pending = 1'b1;
            default: ;
        endcase
        repeat (LATENCY) @(negedge clk);
        poll_count(exp_q.size(), status);
        if (status[4] !== exp_ovf) begin
            flag_error($sformatf("entry %0d overflow %0b, expected %0b", i, status[4], exp_ovf));
        end
        if (s.drain) drain_fifo();
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [31:0] dat;
        key_code_t   seq [9];
        int          waited;
        void'($urandom(32'h690a82a7));
        errors        = 0;
        timeouts      = 0;
        exp_ovf       = 1'b0;
        ghost_pending = 1'b0;
        clk           = 1'b0;
        rst_n         = 1'b0;
        wb_req        = '0;
        rows          = '1;
        pressed_keys  = '0;

        // Single, short, long, ghost pair, then a single that carries the ghost flag
        stim[0] = make_stim('0, key_code_t'($urandom % 16), HOLD_NORM, OUT_ENTRY, 1'b1);
        stim[0].keys = one_key(stim[0].code);
        stim[1] = make_stim(one_key(4'd6), 4'd6, HOLD_SHORT, OUT_NONE, 1'b0);
        stim[2] = make_stim(one_key(4'd9), 4'd9, HOLD_LONG, OUT_ENTRY, 1'b1);
        stim[3] = make_stim(one_key(4'd1) | one_key(4'd5), 4'd0, HOLD_NORM, OUT_GHOST, 1'b0);
        stim[4] = make_stim(one_key(4'd14), 4'd14, HOLD_NORM, OUT_ENTRY, 1'b1);
        // Nine presses, no reads, the last one overflows
        seq = '{4'd0, 4'd5, 4'd10, 4'd15, 4'd3, 4'd6, 4'd9, 4'd12, 4'd2};
        for (int k = 0; k < 9; k++) begin
            stim[5 + k] = make_stim(one_key(seq[k]), seq[k], HOLD_NORM, OUT_ENTRY, 1'b0);
        end
        stim[14] = make_stim(one_key(4'd7), 4'd7, HOLD_NORM, OUT_ENTRY, 1'b0);   // irq
        stim[15] = make_stim(one_key(4'd11), 4'd11, HOLD_NORM, OUT_NONE, 1'b0);  // Scan off

        repeat (2) @(negedge clk);
        if (cols !== '1 || irq !== 1'b0) flag_error("cols or irq active during reset");
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 14; i++) begin
            run_entry(i);
        end
        drain_fifo();                   // Eight in order, then empty
        wb_write(REG_CTRL, 32'h5);      // Keep scan_en, clear overflow
        exp_ovf = 1'b0;
        wb_read(REG_STATUS, dat);
        if (dat[4] !== 1'b0) flag_error("overflow still set after the CTRL clear");
        wb_read(REG_CTRL, dat);         // scan_en only, clear bit reads 0
        if (dat[2:0] !== 3'b001) flag_error($sformatf("CTRL 0x%0h, expected 0x1", dat[2:0]));

        // Interrupt follows a nonempty FIFO
        wb_write(REG_CTRL, 32'h3);
        run_entry(14);
        if (irq !== 1'b1) flag_error("irq low with irq_en set and a nonempty FIFO");
        drain_fifo();
        waited = 0;
        while (irq !== 1'b0 && waited < BUS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (irq !== 1'b0) begin
            timeouts++;
            $display("Timeout: irq stayed high after the FIFO drained");
        end

        // Scanning disabled, columns released
        wb_write(REG_CTRL, 32'h0);
        repeat (2) @(negedge clk);
        if (cols !== '1) flag_error($sformatf("cols 0x%h with scan_en cleared", cols));
        run_entry(15);

        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
design/keypad_pkg.sv
design/wb_pkg.sv
design/keypad_scanner.sv
design/key_encoder.sv
design/keypad_debouncer.sv
design/key_fifo.sv
design/keypad_wb_ctrl.sv
design/keypad_top.sv
bench/keypad_tb.sv
